// ==== src/btb_pkg.sv ====
`default_nettype none

package btb_pkg;

	// 2-bit saturating predictor, values 2 and 3 predict taken
	typedef logic [1:0] ctr_t;

	localparam ctr_t CTR_WEAK_NT = 2'd1;
	localparam ctr_t CTR_WEAK_T = 2'd2;
	localparam ctr_t CTR_MAX = 2'd3;
	localparam ctr_t CTR_MIN = 2'd0;

	// update controller sequence
	typedef enum logic [1:0] {
		IDLE,
		LOOKUP,
		WRITE,
		ACK
	} upd_state_e;

	// buffer depth, kept a power of two
	localparam int DEFAULT_ENTRIES = 8;

	// word address width
	localparam int DEFAULT_ADDR_W = 30;

endpackage

`default_nettype wire

// ==== src/btb_update_if.sv ====
`default_nettype none

interface btb_update_if import btb_pkg::*; #(
	parameter int ENTRIES = DEFAULT_ENTRIES,
	parameter int ADDR_W = DEFAULT_ADDR_W
);

	localparam int IDX_W = $clog2(ENTRIES);

	logic wr_en;
	// set for a new entry, clear for a counter update on a hit
	logic wr_alloc;
	logic [IDX_W-1:0] wr_idx;
	logic [ADDR_W-1:0] wr_tag;
	logic [ADDR_W-1:0] wr_target;
	ctr_t wr_ctr;

	// update controller side
	modport ctrl (
		output wr_en, wr_alloc, wr_idx, wr_tag, wr_target, wr_ctr
	);

	// storage and recency side
	modport sink (
		input wr_en, wr_alloc, wr_idx, wr_tag, wr_target, wr_ctr
	);

endinterface

`default_nettype wire

// ==== src/btb_tag_cam.sv ====
`default_nettype none

module btb_tag_cam import btb_pkg::*; #(
	parameter int ENTRIES = DEFAULT_ENTRIES,
	parameter int ADDR_W = DEFAULT_ADDR_W,
	localparam int IDX_W = $clog2(ENTRIES)
) (
	input wire logic clock_bus_i,
	input wire logic resetn_i,
	btb_update_if.sink upd,
	input wire logic [ADDR_W-1:0] fetch_pc_i,
	output logic fetch_hit_o,
	output logic [IDX_W-1:0] fetch_idx_o,
	input wire logic [ADDR_W-1:0] resolve_pc_i,
	output logic resolve_hit_o,
	output logic [IDX_W-1:0] resolve_idx_o,
	output logic [IDX_W-1:0] free_idx_o,
	output logic full_o
);

	logic [ADDR_W-1:0] tag_q [ENTRIES];
	logic [ENTRIES-1:0] valid_q;
	logic [ENTRIES-1:0] fetch_match;
	logic [ENTRIES-1:0] resolve_match;

	// lowest set bit to index, zero when nothing is set
	function automatic logic [IDX_W-1:0] first_set(input logic [ENTRIES-1:0] bits);
		logic [IDX_W-1:0] idx;
		idx = '0;
		for (int i = ENTRIES - 1; i >= 0; i--) begin
			if (bits[i]) begin
				idx = IDX_W'(i);
			end
		end
		return idx;
	endfunction

	// tags only change on allocation, hit updates keep them
	always_ff @(posedge clock_bus_i) begin
		if (upd.wr_en && upd.wr_alloc) begin
			tag_q[upd.wr_idx] <= upd.wr_tag;
		end
	end

	always_ff @(posedge clock_bus_i) begin
		if (!resetn_i) begin
			valid_q <= '0;
		end else if (upd.wr_en && upd.wr_alloc) begin
			valid_q[upd.wr_idx] <= 1'b1;
		end
	end

	// parallel compare of both ports
	always_comb begin
		for (int i = 0; i < ENTRIES; i++) begin
			fetch_match[i] = valid_q[i] && (tag_q[i] == fetch_pc_i);
			resolve_match[i] = valid_q[i] && (tag_q[i] == resolve_pc_i);
		end
	end

	assign fetch_hit_o = |fetch_match;
	assign fetch_idx_o = first_set(fetch_match);
	assign resolve_hit_o = |resolve_match;
	assign resolve_idx_o = first_set(resolve_match);

	// free slot only meaningful while not full
	assign free_idx_o = first_set(~valid_q);
	assign full_o = &valid_q;

endmodule

`default_nettype wire

// ==== src/btb_entry_array.sv ====
`default_nettype none

module btb_entry_array import btb_pkg::*; #(
	parameter int ENTRIES = DEFAULT_ENTRIES,
	parameter type payload_t = ctr_t,
	localparam int IDX_W = $clog2(ENTRIES)
) (
	input wire logic clock_bus_i,
	input wire logic resetn_i,
	input wire logic wr_en_i,
	input wire logic [IDX_W-1:0] wr_idx_i,
	input wire payload_t wr_data_i,
	input wire logic [IDX_W-1:0] rd_a_idx_i,
	output payload_t rd_a_data_o,
	input wire logic [IDX_W-1:0] rd_b_idx_i,
	output payload_t rd_b_data_o
);

	payload_t mem_q [ENTRIES];

	always_ff @(posedge clock_bus_i) begin
		if (!resetn_i) begin
			for (int i = 0; i < ENTRIES; i++) begin
				mem_q[i] <= '0;
			end
		end else if (wr_en_i) begin
			mem_q[wr_idx_i] <= wr_data_i;
		end
	end

	// asynchronous reads
	assign rd_a_data_o = mem_q[rd_a_idx_i];
	assign rd_b_data_o = mem_q[rd_b_idx_i];

endmodule

`default_nettype wire

// ==== src/lru_age_tracker.sv ====
`default_nettype none

module lru_age_tracker import btb_pkg::*; #(
	parameter int ENTRIES = DEFAULT_ENTRIES,
	localparam int IDX_W = $clog2(ENTRIES),
	localparam int CNT_W = $clog2(ENTRIES + 1)
) (
	input wire logic clock_bus_i,
	input wire logic resetn_i,
	btb_update_if.sink upd,
	input wire logic [CNT_W-1:0] valid_count_i,
	output logic [IDX_W-1:0] oldest_idx_o
);

	// age 0 is the most recently updated entry
	logic [IDX_W-1:0] age_q [ENTRIES];
	logic [ENTRIES-1:0] in_use;
	logic [IDX_W-1:0] wr_age;

	// slots fill from the bottom, so the count marks the allocated range
	always_comb begin
		for (int i = 0; i < ENTRIES; i++) begin
			in_use[i] = CNT_W'(i) < valid_count_i;
		end
	end

	assign wr_age = age_q[upd.wr_idx];

	always_ff @(posedge clock_bus_i) begin
		if (!resetn_i) begin
			for (int i = 0; i < ENTRIES; i++) begin
				age_q[i] <= '0;
			end
		end else if (upd.wr_en) begin
			for (int i = 0; i < ENTRIES; i++) begin
				if (IDX_W'(i) == upd.wr_idx) begin
					age_q[i] <= '0;
				end else if (in_use[i]) begin
					// hit only ages the entries that were younger
					if (upd.wr_alloc || (age_q[i] < wr_age)) begin
						age_q[i] <= age_q[i] + 1'b1;
					end
				end
			end
		end
	end

	// unique once full, ages then form a permutation
	always_comb begin
		oldest_idx_o = '0;
		for (int i = 0; i < ENTRIES; i++) begin
			if (age_q[i] == IDX_W'(ENTRIES - 1)) begin
				oldest_idx_o = IDX_W'(i);
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/btb_update_fsm.sv ====
`default_nettype none

module btb_update_fsm import btb_pkg::*; #(
	parameter int ENTRIES = DEFAULT_ENTRIES,
	parameter int ADDR_W = DEFAULT_ADDR_W,
	localparam int IDX_W = $clog2(ENTRIES),
	localparam int CNT_W = $clog2(ENTRIES + 1)
) (
	input wire logic clock_bus_i,
	input wire logic resetn_i,
	input wire logic resolve_req_i,
	output logic resolve_ack_o,
	input wire logic [ADDR_W-1:0] resolve_pc_i,
	input wire logic [ADDR_W-1:0] resolve_target_i,
	input wire logic resolve_taken_i,
	input wire logic hit_i,
	input wire logic [IDX_W-1:0] hit_idx_i,
	input wire logic [IDX_W-1:0] free_idx_i,
	input wire logic full_i,
	input wire logic [IDX_W-1:0] oldest_idx_i,
	input wire ctr_t old_ctr_i,
	output logic [IDX_W-1:0] ctr_rd_idx_o,
	output logic [CNT_W-1:0] valid_count_o,
	btb_update_if.ctrl upd
);

	upd_state_e state_q;
	upd_state_e state_d;
	logic hit_q;
	logic [IDX_W-1:0] slot_q;
	ctr_t old_ctr_q;
	ctr_t new_ctr;
	logic [CNT_W-1:0] alloc_cnt_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (resolve_req_i) begin
					state_d = LOOKUP;
				end
			end
			LOOKUP: state_d = WRITE;
			WRITE: state_d = ACK;
			// requester holding req keeps us here
			ACK: begin
				if (!resolve_req_i) begin
					state_d = IDLE;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clock_bus_i) begin
		if (!resetn_i) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// lookup results held for the write cycle
	always_ff @(posedge clock_bus_i) begin
		if (state_q == LOOKUP) begin
			hit_q <= hit_i;
			old_ctr_q <= old_ctr_i;
			if (hit_i) begin
				slot_q <= hit_idx_i;
			end else if (full_i) begin
				slot_q <= oldest_idx_i;
			end else begin
				slot_q <= free_idx_i;
			end
		end
	end

	always_ff @(posedge clock_bus_i) begin
		if (!resetn_i) begin
			alloc_cnt_q <= '0;
		end else if (state_q == WRITE && !hit_q && alloc_cnt_q != CNT_W'(ENTRIES)) begin
			alloc_cnt_q <= alloc_cnt_q + 1'b1;
		end
	end

	// saturating step on a hit, weak start on a miss
	always_comb begin
		if (!hit_q) begin
			new_ctr = resolve_taken_i ? CTR_WEAK_T : CTR_WEAK_NT;
		end else if (resolve_taken_i) begin
			new_ctr = (old_ctr_q == CTR_MAX) ? CTR_MAX : old_ctr_q + 1'b1;
		end else begin
			new_ctr = (old_ctr_q == CTR_MIN) ? CTR_MIN : old_ctr_q - 1'b1;
		end
	end

	assign ctr_rd_idx_o = hit_idx_i;
	assign valid_count_o = alloc_cnt_q;
	assign resolve_ack_o = state_q == ACK;

	assign upd.wr_en = state_q == WRITE;
	assign upd.wr_alloc = !hit_q;
	assign upd.wr_idx = slot_q;
	assign upd.wr_tag = resolve_pc_i;
	assign upd.wr_target = resolve_target_i;
	assign upd.wr_ctr = new_ctr;

endmodule

`default_nettype wire

// ==== src/btb_predictor_top.sv ====
`default_nettype none

module btb_predictor_top import btb_pkg::*; #(
	parameter int ENTRIES = DEFAULT_ENTRIES,
	parameter int ADDR_W = DEFAULT_ADDR_W
) (
	input wire logic clock_bus_i,
	input wire logic resetn_i,
	input wire logic [ADDR_W-1:0] fetch_pc_i,
	output logic [ADDR_W+1:0] next_pc_o,
	input wire logic resolve_req_i,
	output logic resolve_ack_o,
	input wire logic [ADDR_W-1:0] resolve_pc_i,
	input wire logic [ADDR_W-1:0] resolve_target_i,
	input wire logic resolve_taken_i
);

	localparam int IDX_W = $clog2(ENTRIES);
	localparam int CNT_W = $clog2(ENTRIES + 1);

	logic fetch_hit;
	logic [IDX_W-1:0] fetch_idx;
	logic resolve_hit;
	logic [IDX_W-1:0] resolve_idx;
	logic [IDX_W-1:0] free_idx;
	logic full;
	logic [IDX_W-1:0] oldest_idx;
	logic [IDX_W-1:0] ctr_rd_idx;
	logic [CNT_W-1:0] valid_count;
	ctr_t fetch_ctr;
	ctr_t resolve_ctr;
	logic [ADDR_W-1:0] fetch_target;
	logic [ADDR_W-1:0] predicted_pc;

	btb_update_if #(.ENTRIES(ENTRIES), .ADDR_W(ADDR_W)) upd ();

	btb_tag_cam #(.ENTRIES(ENTRIES), .ADDR_W(ADDR_W)) btb_tag_cam_inst (
		.clock_bus_i(clock_bus_i),
		.resetn_i(resetn_i),
		.upd(upd.sink),
		.fetch_pc_i(fetch_pc_i),
		.fetch_hit_o(fetch_hit),
		.fetch_idx_o(fetch_idx),
		.resolve_pc_i(resolve_pc_i),
		.resolve_hit_o(resolve_hit),
		.resolve_idx_o(resolve_idx),
		.free_idx_o(free_idx),
		.full_o(full)
	);

	// second read port of the target store is not needed
	// targets only change on allocation, hit updates keep them
	btb_entry_array #(.ENTRIES(ENTRIES), .payload_t(logic [ADDR_W-1:0])) target_store (
		.clock_bus_i(clock_bus_i),
		.resetn_i(resetn_i),
		.wr_en_i(upd.wr_en && upd.wr_alloc),
		.wr_idx_i(upd.wr_idx),
		.wr_data_i(upd.wr_target),
		.rd_a_idx_i(fetch_idx),
		.rd_a_data_o(fetch_target),
		.rd_b_idx_i(resolve_idx),
		.rd_b_data_o()
	);

	btb_entry_array #(.ENTRIES(ENTRIES), .payload_t(ctr_t)) ctr_store (
		.clock_bus_i(clock_bus_i),
		.resetn_i(resetn_i),
		.wr_en_i(upd.wr_en),
		.wr_idx_i(upd.wr_idx),
		.wr_data_i(upd.wr_ctr),
		.rd_a_idx_i(fetch_idx),
		.rd_a_data_o(fetch_ctr),
		.rd_b_idx_i(ctr_rd_idx),
		.rd_b_data_o(resolve_ctr)
	);

	lru_age_tracker #(.ENTRIES(ENTRIES)) lru_age_tracker_inst (
		.clock_bus_i(clock_bus_i),
		.resetn_i(resetn_i),
		.upd(upd.sink),
		.valid_count_i(valid_count),
		.oldest_idx_o(oldest_idx)
	);

	btb_update_fsm #(.ENTRIES(ENTRIES), .ADDR_W(ADDR_W)) btb_update_fsm_inst (
		.clock_bus_i(clock_bus_i),
		.resetn_i(resetn_i),
		.resolve_req_i(resolve_req_i),
		.resolve_ack_o(resolve_ack_o),
		.resolve_pc_i(resolve_pc_i),
		.resolve_target_i(resolve_target_i),
		.resolve_taken_i(resolve_taken_i),
		.hit_i(resolve_hit),
		.hit_idx_i(resolve_idx),
		.free_idx_i(free_idx),
		.full_i(full),
		.oldest_idx_i(oldest_idx),
		.old_ctr_i(resolve_ctr),
		.ctr_rd_idx_o(ctr_rd_idx),
		.valid_count_o(valid_count),
		.upd(upd.ctrl)
	);

	// counter msb set means predict taken
	assign predicted_pc = (fetch_hit && fetch_ctr[1]) ? fetch_target : fetch_pc_i + 1'b1;
	assign next_pc_o = {predicted_pc, 2'b00};

endmodule

`default_nettype wire

// ==== verification/btb_checker.sv ====
`default_nettype none

module btb_checker import btb_pkg::*; (
	input wire logic clock_bus_i,
	input wire logic resetn_i,
	input wire logic req_i,
	input wire logic ack_i,
	input wire logic wr_en_i,
	input wire upd_state_e state_i
);

	timeunit 1ns;
	timeprecision 1ps;

	// number of failed assertions so far
	int fail_count = 0;

	ack_needs_req: assert property (@(posedge clock_bus_i) disable iff (!resetn_i)
		$rose(ack_i) |-> $past(req_i))
		else begin
			$error("ack rose without a pending req");
			fail_count++;
		end

	// ack holds while req is still up, and drops only once req has gone
	ack_holds: assert property (@(posedge clock_bus_i) disable iff (!resetn_i)
		(ack_i && req_i) |=> ack_i)
		else begin
			$error("ack dropped while req was still high");
			fail_count++;
		end

	ack_falls_after_req: assert property (@(posedge clock_bus_i) disable iff (!resetn_i)
		$fell(ack_i) |-> !$past(req_i))
		else begin
			$error("ack fell before req was released");
			fail_count++;
		end

	// the table write sits inside an open handshake, before ack
	wr_en_in_write: assert property (@(posedge clock_bus_i) disable iff (!resetn_i)
		wr_en_i |-> (state_i == WRITE) && req_i && !ack_i)
		else begin
			$error("table write outside the WRITE state of an open handshake");
			fail_count++;
		end

	wr_en_single: assert property (@(posedge clock_bus_i) disable iff (!resetn_i)
		wr_en_i |=> !wr_en_i)
		else begin
			$error("table write lasted more than one cycle");
			fail_count++;
		end

	ack_low_after_reset: assert property (@(posedge clock_bus_i)
		!resetn_i |=> !ack_i)
		else begin
			$error("ack high after a reset cycle");
			fail_count++;
		end

endmodule

bind btb_update_fsm btb_checker handshake_checker_inst (
	.clock_bus_i(clock_bus_i),
	.resetn_i(resetn_i),
	.req_i(resolve_req_i),
	.ack_i(resolve_ack_o),
	.wr_en_i(upd.wr_en),
	.state_i(state_q)
);

`default_nettype wire

// ==== verification/btb_tb.sv ====
`default_nettype none

module btb_tb import btb_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ENTRIES = 8;
	localparam int ADDR_W = 30;
	localparam int POOL_SIZE = 12;
	localparam int NUM_UPDATES = 400;
	localparam int RESET_CYCLES = 3;
	localparam int ACK_BOUND = 8;
	localparam int ACK_LATENCY = 3;
	localparam int MAX_HOLD = 2;
	localparam int MAX_GAP = 3;
	// request cycle, ack wait, hold, two release cycles and the idle gap per update
	localparam int WATCHDOG_CYCLES =
		RESET_CYCLES + 8 + NUM_UPDATES * (1 + ACK_BOUND + MAX_HOLD + 2 + MAX_GAP) + 200;

	logic clock_bus_i;
	logic resetn_i;
	logic [ADDR_W-1:0] fetch_pc_i;
	logic [ADDR_W+1:0] next_pc_o;
	logic resolve_req_i;
	logic resolve_ack_o;
	logic [ADDR_W-1:0] resolve_pc_i;
	logic [ADDR_W-1:0] resolve_target_i;
	logic resolve_taken_i;

	// reference model of the table
	logic m_valid [ENTRIES];
	logic [ADDR_W-1:0] m_tag [ENTRIES];
	logic [ADDR_W-1:0] m_target [ENTRIES];
	ctr_t m_ctr [ENTRIES];
	// front holds the least recently updated slot
	int recency [$];

	logic [ADDR_W-1:0] pool [POOL_SIZE];
	int taken_bias [POOL_SIZE];

	// failed assertions counted by the bound checker
	int checker_fail_count;

	btb_predictor_top #(.ENTRIES(ENTRIES), .ADDR_W(ADDR_W)) btb_predictor_top_inst (
		.clock_bus_i(clock_bus_i),
		.resetn_i(resetn_i),
		.fetch_pc_i(fetch_pc_i),
		.next_pc_o(next_pc_o),
		.resolve_req_i(resolve_req_i),
		.resolve_ack_o(resolve_ack_o),
		.resolve_pc_i(resolve_pc_i),
		.resolve_target_i(resolve_target_i),
		.resolve_taken_i(resolve_taken_i)
	);

	assign checker_fail_count =
		btb_predictor_top_inst.btb_update_fsm_inst.handshake_checker_inst.fail_count;

	initial begin
		clock_bus_i = 1'b0;
		forever begin
			#4 clock_bus_i = ~clock_bus_i;
		end
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("sim failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_next_pc(input logic [ADDR_W+1:0] actual,
		input logic [ADDR_W+1:0] expected);
		if (actual !== expected) begin
			abort_run($sformatf("mismatch at %0t: next_pc_o got %h expected %h",
				$time, actual, expected));
		end
	endtask

	task automatic check_ack_level(input logic actual, input logic expected);
		if (actual !== expected) begin
			abort_run($sformatf("mismatch at %0t: resolve_ack_o got %b expected %b",
				$time, actual, expected));
		end
	endtask

	function automatic int find_slot(input logic [ADDR_W-1:0] pc);
		int slot;
		slot = -1;
		for (int i = 0; i < ENTRIES; i++) begin
			if (m_valid[i] && m_tag[i] == pc) slot = i;
		end
		return slot;
	endfunction

	// taken prediction needs a hit and a counter of 2 or 3
	function automatic logic [ADDR_W+1:0] expected_next_pc(input logic [ADDR_W-1:0] pc);
		logic [ADDR_W-1:0] pred;
		int slot;
		slot = find_slot(pc);
		pred = pc + ADDR_W'(1);
		if (slot >= 0 && m_ctr[slot] >= 2'd2) pred = m_target[slot];
		return {pred, 2'b00};
	endfunction

	task automatic touch_recency(input int slot);
		int pos;
		pos = -1;
		foreach (recency[i]) begin
			if (recency[i] == slot) pos = i;
		end
		if (pos >= 0) recency.delete(pos);
		recency.push_back(slot);
	endtask

	task automatic model_update(input logic [ADDR_W-1:0] pc, input logic [ADDR_W-1:0] target,
		input logic taken);
		int slot;
		slot = find_slot(pc);
		if (slot >= 0) begin
			if (taken && m_ctr[slot] != 2'd3) m_ctr[slot] = m_ctr[slot] + 2'd1;
			if (!taken && m_ctr[slot] != 2'd0) m_ctr[slot] = m_ctr[slot] - 2'd1;
		end else begin
			for (int i = ENTRIES - 1; i >= 0; i--) begin
				if (!m_valid[i]) slot = i;
			end
			// full buffer replaces the least recently updated entry
			if (slot < 0) slot = recency[0];
			m_valid[slot] = 1'b1;
			m_tag[slot] = pc;
			m_target[slot] = target;
			m_ctr[slot] = taken ? 2'd2 : 2'd1;
		end
		touch_recency(slot);
	endtask

	// 70% of fetches hit the branch pool
	function automatic logic [ADDR_W-1:0] pick_fetch_pc();
		if ($urandom_range(99) < 70) return pool[$urandom_range(POOL_SIZE - 1)];
		return ADDR_W'($urandom);
	endfunction

	task automatic next_cycle();
		@(posedge clock_bus_i);
		#1;
		fetch_pc_i = pick_fetch_pc();
	endtask

	task automatic run_update(input int sel);
		logic [ADDR_W-1:0] target;
		logic taken;
		int waited;
		target = ADDR_W'($urandom);
		taken = $urandom_range(99) < 32'(taken_bias[sel]);
		next_cycle();
		resolve_pc_i = pool[sel];
		resolve_target_i = target;
		resolve_taken_i = taken;
		resolve_req_i = 1'b1;
		#4;
		check_ack_level(resolve_ack_o, 1'b0);
		check_next_pc(next_pc_o, expected_next_pc(fetch_pc_i));
		waited = 0;
		do begin
			next_cycle();
			waited++;
			#4;
			if (!resolve_ack_o) check_next_pc(next_pc_o, expected_next_pc(fetch_pc_i));
		end while (!resolve_ack_o && waited < ACK_BOUND);
		if (!resolve_ack_o) abort_run("no acknowledge within the update bound");
		if (waited != ACK_LATENCY) begin
			abort_run($sformatf("acknowledge came after %0d cycles instead of %0d",
				waited, ACK_LATENCY));
		end
		// written entry is visible to fetch from the first ack cycle
		model_update(pool[sel], target, taken);
		check_next_pc(next_pc_o, expected_next_pc(fetch_pc_i));
		repeat ($urandom_range(MAX_HOLD)) begin
			next_cycle();
			#4;
			check_ack_level(resolve_ack_o, 1'b1);
			check_next_pc(next_pc_o, expected_next_pc(fetch_pc_i));
		end
		next_cycle();
		resolve_req_i = 1'b0;
		resolve_pc_i = ADDR_W'($urandom);
		resolve_target_i = ADDR_W'($urandom);
		resolve_taken_i = 1'($urandom);
		#4;
		check_ack_level(resolve_ack_o, 1'b1);
		check_next_pc(next_pc_o, expected_next_pc(fetch_pc_i));
		next_cycle();
		#4;
		check_ack_level(resolve_ack_o, 1'b0);
		check_next_pc(next_pc_o, expected_next_pc(fetch_pc_i));
	endtask

	// distinct branch addresses, each with its own taken rate
	task automatic build_pool();
		logic [ADDR_W-1:0] cand;
		logic fresh;
		for (int i = 0; i < POOL_SIZE; i++) begin
			do begin
				cand = ADDR_W'($urandom);
				fresh = 1'b1;
				for (int j = 0; j < i; j++) begin
					if (pool[j] == cand) fresh = 1'b0;
				end
			end while (!fresh);
			pool[i] = cand;
			taken_bias[i] = 10 + 40 * int'($urandom_range(2));
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock_bus_i);
		abort_run("watchdog expired before the test sequence finished");
	end

	initial begin
		forever begin
			@(posedge clock_bus_i);
			#2;
			if (checker_fail_count != 0) begin
				abort_run("a handshake assertion in the bound checker failed");
			end
		end
	end

	initial begin
		void'($urandom(32'h3c67875e));
		resetn_i = 1'b0;
		fetch_pc_i = '0;
		resolve_req_i = 1'b0;
		resolve_pc_i = '0;
		resolve_target_i = '0;
		resolve_taken_i = 1'b0;
		for (int i = 0; i < ENTRIES; i++) begin
			m_valid[i] = 1'b0;
			m_tag[i] = '0;
			m_target[i] = '0;
			m_ctr[i] = 2'd0;
		end
		build_pool();
		repeat (RESET_CYCLES) @(posedge clock_bus_i);
		#1;
		resetn_i = 1'b1;
		// empty table predicts the sequential address
		repeat (8) begin
			next_cycle();
			#4;
			check_ack_level(resolve_ack_o, 1'b0);
			check_next_pc(next_pc_o, expected_next_pc(fetch_pc_i));
		end
		for (int n = 0; n < NUM_UPDATES; n++) begin
			run_update(int'($urandom_range(POOL_SIZE - 1)));
			repeat ($urandom_range(MAX_GAP)) begin
				next_cycle();
				#4;
				check_next_pc(next_pc_o, expected_next_pc(fetch_pc_i));
			end
		end
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
src/btb_pkg.sv
src/btb_update_if.sv
src/btb_tag_cam.sv
src/btb_entry_array.sv
src/lru_age_tracker.sv
src/btb_update_fsm.sv
src/btb_predictor_top.sv
verification/btb_checker.sv
verification/btb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the branch target buffer testbench with Verilator, then run it.
# A failing check ends the simulation with $fatal, which gives a non-zero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f build.f \
	--top-module btb_tb \
	-Mdir obj_dir \
	-o btb_sim

# let assertion errors reach the testbench instead of stopping at the first one
./obj_dir/btb_sim +verilator+error+limit+100
